// ==== alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  alu_op_e op_i,
	input  word_t   a_i,
	input  word_t   b_i,
	output word_t   result_o
);

	// All results wrap modulo 2^32.
	always_comb
	begin
		case (op_i)
			ALU_ADD: result_o = a_i + b_i;
			ALU_SUB: result_o = a_i - b_i;
			ALU_MUL: result_o = a_i * b_i;	// Low 32 bits of product.
			ALU_AND: result_o = a_i & b_i;
			ALU_OR:  result_o = a_i | b_i;
			default: result_o = '0;
		endcase
	end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field and data widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] word_t;		// Data word, address and PC.
	typedef logic [31:0] instr_t;		// Raw instruction.
	typedef logic [4:0]  reg_addr_t;	// Register index.
	typedef logic [5:0]  opcode_t;		// Bits 31:26.
	typedef logic [5:0]  func_t;		// Bits 5:0 of R-type.
	typedef logic [7:0]  mem_addr_t;	// Data memory word index.

	localparam int NUM_REGS  = 32;
	localparam int MEM_WORDS = 256;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2B;
	localparam opcode_t OP_J     = 6'h02;
	localparam opcode_t OP_BEQ   = 6'h04;

	localparam func_t FN_ADD = 6'h20;
	localparam func_t FN_SUB = 6'h22;
	localparam func_t FN_MUL = 6'h18;
	localparam func_t FN_AND = 6'h24;
	localparam func_t FN_OR  = 6'h25;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_MUL,
		ALU_AND,
		ALU_OR
	} alu_op_e;

	// Upper bit picks a taken jump or branch, lower bit picks branch over jump.
	typedef enum logic [1:0] {
		PC_SEQ    = 2'b00,	// PC + 4.
		PC_JUMP   = 2'b10,	// Pseudo-direct target.
		PC_BRANCH = 2'b11	// PC + 4 + offset.
	} pc_sel_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control groups per stage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;	// 1 selects immediate as operand B.
		logic    reg_dst_rd;	// 1 selects rd, else rt.
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_cs;
		logic mem_we;
	} mem_ctrl_t;

	typedef struct packed {
		logic wb_from_alu;	// 0 takes memory read data.
		logic reg_we;
	} wb_ctrl_t;

endpackage

// ==== data_memory.sv ====
`timescale 1ns/1ps

module data_memory import cpu_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  mem_ctrl_t ctrl_i,
	input  mem_addr_t addr_i,
	input  word_t     wr_data_i,
	output word_t     rd_data_o
);

	word_t mem [MEM_WORDS];

	assign rd_data_o = ctrl_i.mem_cs ? mem[addr_i] : '0;	// Idle reads zero.

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0;
		end
		else if (ctrl_i.mem_cs && ctrl_i.mem_we)
			mem[addr_i] <= wr_data_i;
	end

endmodule

// ==== general_control.sv ====
`timescale 1ns/1ps

module general_control import cpu_pkg::*; (
	input  opcode_t   op_i,
	input  func_t     func_i,
	input  logic      eq_flag_i,
	output pc_sel_e   pc_sel_o,
	output ex_ctrl_t  ex_ctrl_o,
	output mem_ctrl_t mem_ctrl_o,
	output wb_ctrl_t  wb_ctrl_o
);

	always_comb
	begin
		// Unknown encodings fall through as a no-op.
		pc_sel_o   = PC_SEQ;
		ex_ctrl_o  = '0;
		mem_ctrl_o = '0;
		wb_ctrl_o  = '0;
		case (op_i)
			OP_RTYPE:
			begin
				ex_ctrl_o.reg_dst_rd = 1'b1;	// Result goes to rd.
				wb_ctrl_o            = '{wb_from_alu: 1'b1, reg_we: 1'b1};
				case (func_i)
					FN_ADD:  ex_ctrl_o.alu_op = ALU_ADD;
					FN_SUB:  ex_ctrl_o.alu_op = ALU_SUB;
					FN_MUL:  ex_ctrl_o.alu_op = ALU_MUL;
					FN_AND:  ex_ctrl_o.alu_op = ALU_AND;
					FN_OR:   ex_ctrl_o.alu_op = ALU_OR;
					default:
					begin
						ex_ctrl_o = '0;
						wb_ctrl_o = '0;	// No write.
					end
				endcase
			end

			OP_ADDI:
			begin
				ex_ctrl_o = '{alu_op: ALU_ADD, alu_src_imm: 1'b1, reg_dst_rd: 1'b0};
				wb_ctrl_o = '{wb_from_alu: 1'b1, reg_we: 1'b1};
			end

			OP_LW:
			begin
				ex_ctrl_o  = '{alu_op: ALU_ADD, alu_src_imm: 1'b1, reg_dst_rd: 1'b0};
				mem_ctrl_o = '{mem_cs: 1'b1, mem_we: 1'b0};
				wb_ctrl_o  = '{wb_from_alu: 1'b0, reg_we: 1'b1};
			end

			OP_SW:
			begin
				ex_ctrl_o  = '{alu_op: ALU_ADD, alu_src_imm: 1'b1, reg_dst_rd: 1'b0};
				mem_ctrl_o = '{mem_cs: 1'b1, mem_we: 1'b1};
			end

			OP_J:
				pc_sel_o = PC_JUMP;

			OP_BEQ:
			begin
				if (eq_flag_i)
					pc_sel_o = PC_BRANCH;	// Taken.
			end

			default:
				pc_sel_o = PC_SEQ;
		endcase
	end

	// Decoder invariants seen by memory and register file.
	always_comb
	begin
		assert (!(mem_ctrl_o.mem_we && !mem_ctrl_o.mem_cs))
			else $error("mem_we without mem_cs");
		assert (!(wb_ctrl_o.reg_we && mem_ctrl_o.mem_we))
			else $error("reg_we and mem_we both set");
	end

endmodule

// ==== mips_core.sv ====
`timescale 1ns/1ps

module mips_core import cpu_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  instr_t    instr_i,
	output word_t     pc_o,
	output logic      wb_we_o,
	output reg_addr_t wb_addr_o,
	output word_t     wb_data_o
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction fields
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	opcode_t     op;
	func_t       func;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [15:0] imm;
	logic [25:0] target;

	assign op     = instr_i[31:26];
	assign rs     = instr_i[25:21];
	assign rt     = instr_i[20:16];
	assign rd     = instr_i[15:11];
	assign imm    = instr_i[15:0];
	assign func   = instr_i[5:0];
	assign target = instr_i[25:0];

	pc_sel_e   pc_sel;
	ex_ctrl_t  ex_ctrl;
	mem_ctrl_t mem_ctrl;
	wb_ctrl_t  wb_ctrl;

	word_t rs_data;
	word_t rt_data;
	word_t imm_ext;
	word_t alu_b;
	word_t alu_result;
	word_t mem_rd_data;
	logic  eq_flag;

	assign eq_flag = (rs_data == rt_data);	// BEQ condition.
	assign imm_ext = {{16{imm[15]}}, imm};

	general_control general_control_i (
		.op_i       (op),
		.func_i     (func),
		.eq_flag_i  (eq_flag),
		.pc_sel_o   (pc_sel),
		.ex_ctrl_o  (ex_ctrl),
		.mem_ctrl_o (mem_ctrl),
		.wb_ctrl_o  (wb_ctrl)
	);

	pc_unit pc_unit_i (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.pc_sel_i (pc_sel),
		.imm_i    (imm),
		.target_i (target),
		.pc_o     (pc_o)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign wb_addr_o = ex_ctrl.reg_dst_rd ? rd : rt;
	assign wb_we_o   = wb_ctrl.reg_we && !rst_i;	// No write during reset.
	assign wb_data_o = wb_ctrl.wb_from_alu ? alu_result : mem_rd_data;

	register_file register_file_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.rs_addr_i (rs),
		.rt_addr_i (rt),
		.wr_addr_i (wb_addr_o),
		.we_i      (wb_we_o),
		.wr_data_i (wb_data_o),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data)
	);

	assign alu_b = ex_ctrl.alu_src_imm ? imm_ext : rt_data;

	alu alu_i (
		.op_i     (ex_ctrl.alu_op),
		.a_i      (rs_data),
		.b_i      (alu_b),
		.result_o (alu_result)
	);

	data_memory data_memory_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.ctrl_i    (mem_ctrl),
		.addr_i    (alu_result[9:2]),	// Byte address to word index.
		.wr_data_i (rt_data),
		.rd_data_o (mem_rd_data)
	);

endmodule

// ==== pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit import cpu_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  pc_sel_e     pc_sel_i,
	input  logic [15:0] imm_i,
	input  logic [25:0] target_i,
	output word_t       pc_o
);

	word_t pc_plus4;
	word_t pc_jump;
	word_t pc_branch;
	word_t pc_next;

	assign pc_plus4  = pc_o + 32'd4;
	assign pc_jump   = {pc_plus4[31:28], target_i, 2'b00};	// Same 256 MB region.
	assign pc_branch = pc_plus4 + {{14{imm_i[15]}}, imm_i, 2'b00};

	always_comb
	begin
		case (pc_sel_i)
			PC_JUMP:   pc_next = pc_jump;
			PC_BRANCH: pc_next = pc_branch;
			default:   pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			pc_o <= '0;
		else
			pc_o <= pc_next;
	end

	a_pc_aligned: assert property (@(posedge clk_i) pc_o[1:0] == 2'b00)
		else $error("PC not word aligned");

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  reg_addr_t rs_addr_i,
	input  reg_addr_t rt_addr_i,
	input  reg_addr_t wr_addr_i,
	input  logic      we_i,
	input  word_t     wr_data_i,
	output word_t     rs_data_o,
	output word_t     rt_data_o
);

	word_t regs [NUM_REGS];

	// Reads see the value before this cycle's write.
	assign rs_data_o = regs[rs_addr_i];
	assign rt_data_o = regs[rt_addr_i];

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (we_i && (wr_addr_i != '0))	// $zero stays hardwired.
			regs[wr_addr_i] <= wr_data_i;
	end

	a_zero_reg: assert property (@(posedge clk_i) disable iff (rst_i)
		(rs_addr_i == '0) |-> (rs_data_o == '0))
		else $error("register zero not zero");

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert --top-module tb_mips_core -f tb.f

out=$(./obj_dir/Vtb_mips_core 2>&1) || true
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
echo "Simulation did not pass"
exit 1

// ==== tb.f ====
cpu_pkg.sv
alu.sv
data_memory.sv
general_control.sv
pc_unit.sv
register_file.sv
mips_core.sv
tb_mips_core.sv

// ==== tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core import cpu_pkg::*; ();

	localparam int RESET_CYCLES   = 10;
	localparam int N_ALU          = 400;
	localparam int N_MEM          = 200;
	localparam int N_FLOW         = 100;
	localparam int N_UNDEF        = 40;
	localparam int TIMEOUT_CYCLES = N_ALU + N_MEM + N_FLOW + N_UNDEF + RESET_CYCLES + 50;

	logic      clk;
	logic      rst;
	instr_t    instr;
	word_t     pc;
	logic      wb_we;
	reg_addr_t wb_addr;
	word_t     wb_data;

	logic [15:0] lfsr = 16'd52;
	word_t       model_regs [NUM_REGS];
	word_t       model_mem [MEM_WORDS];
	word_t       model_pc;
	int          cycles = 0;
	string       test_name;

	mips_core mips_core_i (
		.clk_i     (clk),
		.rst_i     (rst),
		.instr_i   (instr),
		.pc_o      (pc),
		.wb_we_o   (wb_we),
		.wb_addr_o (wb_addr),
		.wb_data_o (wb_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
			begin
				$display("Timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES);
				$display("*** TEST FAILED ***");
				$fatal(1, "timeout");
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus generation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic lfsr_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];	// x^16 + x^14 + x^13 + x^11 + 1.
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic word_t rand_bits(input int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// Five R-type codes and ADDI, R-type weighted 5 to 3.
	function automatic instr_t alu_instr();
		word_t sel;
		word_t r;
		func_t fn;
		sel = rand_bits(3);
		r   = rand_bits(26);
		case (sel[2:0])
			3'd0:    fn = FN_ADD;
			3'd1:    fn = FN_SUB;
			3'd2:    fn = FN_MUL;
			3'd3:    fn = FN_AND;
			default: fn = FN_OR;
		endcase
		if (sel[2:0] > 3'd4)
			return {OP_ADDI, r[25:0]};
		return {OP_RTYPE, r[14:0], 5'd0, fn};
	endfunction

	// Base register zero, so the word index is imm[5:2].
	function automatic instr_t mem_instr();
		word_t r;
		r = rand_bits(10);
		return {(r[9] ? OP_SW : OP_LW), 5'd0, r[8:4], 10'd0, r[3:0], 2'b00};
	endfunction

	function automatic instr_t flow_instr();
		word_t r;
		r = rand_bits(28);
		if (r[27])
			return {OP_J, r[25:0]};
		return {OP_BEQ, r[25:21], (r[26] ? r[25:21] : r[20:16]), r[15:0]};	// Bit 26 forces equal.
	endfunction

	function automatic logic is_undefined(input instr_t ins);
		if (ins[31:26] == OP_RTYPE)
			return !(ins[5:0] inside {FN_ADD, FN_SUB, FN_MUL, FN_AND, FN_OR});
		return !(ins[31:26] inside {OP_ADDI, OP_LW, OP_SW, OP_J, OP_BEQ});
	endfunction

	function automatic instr_t undef_instr();
		logic  pick_rtype;
		word_t r;
		pick_rtype = lfsr_bit();
		r          = rand_bits(32);
		if (pick_rtype)
			r[31:26] = OP_RTYPE;
		while (!is_undefined(r))
		begin
			r = rand_bits(32);
			if (pick_rtype)
				r[31:26] = OP_RTYPE;
		end
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic execute_model(input instr_t ins);
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t exp_addr;
		word_t     a;
		word_t     b;
		word_t     simm;
		word_t     ea;
		word_t     pc4;
		word_t     next_pc;
		word_t     exp_data;
		logic      exp_we;
		logic      do_store;
		rs       = ins[25:21];
		rt       = ins[20:16];
		a        = model_regs[rs];
		b        = model_regs[rt];
		simm     = {{16{ins[15]}}, ins[15:0]};
		ea       = a + simm;	// Also the ADDI result.
		pc4      = model_pc + 32'd4;
		next_pc  = pc4;
		exp_we   = 1'b0;
		exp_addr = rt;
		exp_data = '0;
		do_store = 1'b0;
		case (ins[31:26])
			OP_RTYPE:
			begin
				exp_we   = 1'b1;
				exp_addr = ins[15:11];
				case (ins[5:0])
					FN_ADD:  exp_data = a + b;
					FN_SUB:  exp_data = a - b;
					FN_MUL:  exp_data = a * b;
					FN_AND:  exp_data = a & b;
					FN_OR:   exp_data = a | b;
					default: exp_we = 1'b0;
				endcase
			end
			OP_ADDI:
			begin
				exp_we   = 1'b1;
				exp_data = ea;
			end
			OP_LW:
			begin
				exp_we   = 1'b1;
				exp_data = model_mem[ea[9:2]];
			end
			OP_SW:  do_store = 1'b1;
			OP_J:   next_pc = {pc4[31:28], ins[25:0], 2'b00};
			OP_BEQ:
			begin
				if (a == b)
					next_pc = pc4 + {simm[29:0], 2'b00};
			end
			default: ;
		endcase
		check_value({test_name, " wb_we"}, 32'(exp_we), 32'(wb_we));
		if (exp_we)
		begin
			check_value({test_name, " wb_addr"}, 32'(exp_addr), 32'(wb_addr));
			check_value({test_name, " wb_data"}, exp_data, wb_data);
		end
		if (exp_we && exp_addr != 5'd0)
			model_regs[exp_addr] = exp_data;
		if (do_store)
			model_mem[ea[9:2]] = b;
		model_pc = next_pc;
	endtask

	// Called at a falling edge; returns at the next one.
	task automatic run_instr(input instr_t ins);
		instr = ins;
		#5;
		execute_model(ins);
		@(negedge clk);
		check_value({test_name, " pc"}, model_pc, pc);
	endtask

	initial
	begin
		rst   = 1'b1;
		instr = '0;
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = '0;
		model_pc  = '0;
		test_name = "reset";
		repeat (RESET_CYCLES - 1)
		begin
			@(negedge clk);
			instr = alu_instr();	// Must not write while in reset.
			#5;
			check_value("reset pc", '0, pc);
			check_value("reset wb_we", '0, 32'(wb_we));
		end
		@(negedge clk);
		rst = 1'b0;
		check_value("reset pc", '0, pc);

		test_name = "alu";
		repeat (N_ALU) run_instr(alu_instr());
		test_name = "memory";
		repeat (N_MEM) run_instr(mem_instr());
		test_name = "control flow";
		repeat (N_FLOW) run_instr(flow_instr());
		test_name = "undefined";
		repeat (N_UNDEF) run_instr(undef_instr());

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
